// File: Makefile
# verilator build and run of the load/store stage testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, and search sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f src.f \
		--top-module tb_ls_stage -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hdl/data_ram.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module data_ram (
    input  logic             clk,
    input  logic             rst_n_i,
    input  lsu_pkg::wb_m2s_t bus_i,
    output lsu_pkg::wb_s2m_t bus_o
);

    localparam int AW = $clog2(`LSU_RAM_WORDS);
    localparam int NB = `LSU_XLEN / 8;

    logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];
    logic [AW-1:0]        idx;
    logic                 hit;
    logic                 ack_q;
    logic [`LSU_XLEN-1:0] rdat_q;

    // word index, byte offset bits dropped
    assign idx = bus_i.adr[AW+2:3];

    // new request, not the cycle already being acked
    assign hit = bus_i.cyc && bus_i.stb && !ack_q;

    // byte-lane write and full-word read
    always_ff @(posedge clk) begin
        if (hit && bus_i.we) begin
            for (int b = 0; b < NB; b++) begin
                if (bus_i.sel[b]) begin
                    mem[idx][8*b +: 8] <= bus_i.dat[8*b +: 8];
                end
            end
        end
        // read data lines up with ack
        if (hit) begin
            rdat_q <= mem[idx];
        end
    end

    // single cycle ack, one wait state
    // low again once stb goes away
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= hit;
        end
    end

    assign bus_o.ack = ack_q;
    assign bus_o.dat = rdat_q;

endmodule

// File: hdl/lane_align.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lane_align (
    input  lsu_pkg::mem_req_t      req_i,
    output logic [`LSU_XLEN/8-1:0] sel_o,
    output logic [`LSU_XLEN-1:0]   wdata_o,
    output lsu_pkg::mem_req_t      req_o
);
    import lsu_pkg::*;

    localparam int NB = `LSU_XLEN / 8;

    logic [2:0]    off;
    logic [5:0]    bit_off;
    logic [NB-1:0] base_sel;

    // byte offset inside the 64-bit word
    assign off     = req_i.addr[2:0];
    // same offset in bits
    assign bit_off = {off, 3'b000};

    // lanes covered at offset zero
    always_comb begin
        case (req_i.size)
            SZ_BYTE: begin
                base_sel = 8'b0000_0001;
            end
            SZ_HALF: begin
                base_sel = 8'b0000_0011;
            end
            SZ_WORD: begin
                base_sel = 8'b0000_1111;
            end
            default: begin
                base_sel = 8'b1111_1111;
            end
        endcase
    end

    // move the lane mask up to the start byte
    // aligned requests never run past lane 7
    assign sel_o = base_sel << off;

    // each store byte onto its own lane
    // bytes above the access width are masked by sel
    assign wdata_o = req_i.wdata << bit_off;

    // request goes on unchanged for the master
    assign req_o = req_i;

endmodule

// File: hdl/load_extend.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module load_extend (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 fin_i,
    input  logic                 fin_load_i,
    input  lsu_pkg::acc_size_e   fin_size_i,
    input  logic                 fin_unsigned_i,
    input  logic [2:0]           fin_off_i,
    input  logic [`LSU_XLEN-1:0] rdata_i,
    input  logic                 misalign_i,
    output logic                 done_o,
    output logic [`LSU_XLEN-1:0] result_o,
    output logic                 misalign_o
);
    import lsu_pkg::*;

    logic [`LSU_XLEN-1:0] shifted;
    logic [`LSU_XLEN-1:0] ext;

    // addressed byte down to bit 0
    assign shifted = rdata_i >> {fin_off_i, 3'b000};

    // keep the field, then sign or zero fill
    always_comb begin
        case (fin_size_i)
            SZ_BYTE: begin
                ext = {{(`LSU_XLEN-8){shifted[7] & !fin_unsigned_i}}, shifted[7:0]};
            end
            SZ_HALF: begin
                ext = {{(`LSU_XLEN-16){shifted[15] & !fin_unsigned_i}}, shifted[15:0]};
            end
            SZ_WORD: begin
                ext = {{(`LSU_XLEN-32){shifted[31] & !fin_unsigned_i}}, shifted[31:0]};
            end
            default: begin
                ext = shifted;
            end
        endcase
    end

    // done and misalign pulse together
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            done_o     <= 1'b0;
            misalign_o <= 1'b0;
        end else begin
            done_o     <= fin_i;
            misalign_o <= fin_i && misalign_i;
        end
    end

    // stores and non-memory ops give zero
    always_ff @(posedge clk) begin
        if (fin_i) begin
            result_o <= fin_load_i ? ext : '0;
        end
    end

endmodule

// File: hdl/ls_decode.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module ls_decode (
    input  logic [31:0]          instr_i,
    input  logic [31:0]          instr_last_i,
    input  logic [`LSU_XLEN-1:0] addr_i,
    input  logic [`LSU_XLEN-1:0] rs2_i,
    input  logic [`LSU_XLEN-1:0] wb_data_i,
    output lsu_pkg::mem_req_t    req_o,
    output logic                 misalign_o
);
    import lsu_pkg::*;

    logic       is_ld;
    logic       is_st;
    logic       last_ld;
    logic       fwd;
    logic       bad_align;
    logic [2:0] funct3;
    acc_size_e  size;

    // funct3 carries both width and sign mode
    assign funct3 = instr_i[14:12];
    assign size   = acc_size_e'(funct3[1:0]);

    // opcode class, low two bits must be 11 for a 32-bit instruction
    assign is_ld = (instr_i[6:2] == `LSU_OPC_LOAD) && (instr_i[1:0] == 2'b11);
    assign is_st = (instr_i[6:2] == `LSU_OPC_STORE) && (instr_i[1:0] == 2'b11);

    // previous instruction was a load
    assign last_ld = (instr_last_i[6:2] == `LSU_OPC_LOAD) && (instr_last_i[1:0] == 2'b11);

    // load result not yet in the register file
    // x0 never forwards
    assign fwd = last_ld && (instr_last_i[11:7] == instr_i[24:20])
                 && (instr_last_i[11:7] != 5'd0);

    // natural alignment check against the access width
    always_comb begin
        case (size)
            SZ_BYTE: bad_align = 1'b0;
            SZ_HALF: bad_align = addr_i[0];
            SZ_WORD: bad_align = |addr_i[1:0];
            default: bad_align = |addr_i[2:0];
        endcase
    end

    // only memory instructions can be misaligned
    assign misalign_o = (is_ld || is_st) && bad_align;

    // misaligned access makes no bus cycle
    assign req_o.is_load     = is_ld && !bad_align;
    assign req_o.is_store    = is_st && !bad_align;
    assign req_o.unsigned_ld = funct3[2];
    assign req_o.size        = size;
    assign req_o.addr        = addr_i;
    // store data with load-use forwarding
    assign req_o.wdata       = fwd ? wb_data_i : rs2_i;

endmodule

// File: hdl/ls_stage.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module ls_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  logic [31:0]          instr_i,
    input  logic [31:0]          instr_last_i,
    input  logic [`LSU_XLEN-1:0] addr_i,
    input  logic [`LSU_XLEN-1:0] rs2_i,
    input  logic [`LSU_XLEN-1:0] wb_data_i,
    output logic                 ready_o,
    output logic                 done_o,
    output logic                 misalign_o,
    output logic [`LSU_XLEN-1:0] result_o
);
    import lsu_pkg::*;

    mem_req_t               dec_req;
    mem_req_t               aln_req;
    logic                   dec_misalign;
    logic [`LSU_XLEN/8-1:0] aln_sel;
    logic [`LSU_XLEN-1:0]   aln_wdata;
    wb_m2s_t                wb_m2s;
    wb_s2m_t                wb_s2m;
    logic                   fin;
    logic                   fin_load;
    acc_size_e              fin_size;
    logic                   fin_unsigned;
    logic [2:0]             fin_off;
    logic                   fin_misalign;
    logic [`LSU_XLEN-1:0]   rdata;

    // decode, alignment check, store forwarding
    ls_decode u_decode (
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .addr_i       (addr_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .req_o        (dec_req),
        .misalign_o   (dec_misalign)
    );

    lane_align u_align (
        .req_i   (dec_req),
        .sel_o   (aln_sel),
        .wdata_o (aln_wdata),
        .req_o   (aln_req)
    );

    // valid_i is the start strobe, accepted while ready
    wb_master u_master (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .start_i        (valid_i),
        .req_i          (aln_req),
        .misalign_i     (dec_misalign),
        .sel_i          (aln_sel),
        .wdata_i        (aln_wdata),
        .bus_i          (wb_s2m),
        .bus_o          (wb_m2s),
        .ready_o        (ready_o),
        .fin_o          (fin),
        .fin_load_o     (fin_load),
        .fin_size_o     (fin_size),
        .fin_unsigned_o (fin_unsigned),
        .fin_off_o      (fin_off),
        .fin_misalign_o (fin_misalign),
        .rdata_o        (rdata)
    );

    load_extend u_extend (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fin_i          (fin),
        .fin_load_i     (fin_load),
        .fin_size_i     (fin_size),
        .fin_unsigned_i (fin_unsigned),
        .fin_off_i      (fin_off),
        .rdata_i        (rdata),
        .misalign_i     (fin_misalign),
        .done_o         (done_o),
        .result_o       (result_o),
        .misalign_o     (misalign_o)
    );

    data_ram u_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus_i   (wb_m2s),
        .bus_o   (wb_s2m)
    );

endmodule

// File: hdl/lsu_pkg.sv
`include "lsu_settings.svh"

package lsu_pkg;

    // access width, taken straight from funct3[1:0]
    typedef enum logic [1:0] {
        SZ_BYTE   = 2'b00,
        SZ_HALF   = 2'b01,
        SZ_WORD   = 2'b10,
        SZ_DOUBLE = 2'b11
    } acc_size_e;

    // one decoded memory request
    typedef struct packed {
        logic                 is_load;
        logic                 is_store;
        // funct3[2], zero extension on loads
        logic                 unsigned_ld;
        acc_size_e            size;
        // full byte address from the alu
        logic [`LSU_XLEN-1:0] addr;
        // store data, still right-aligned
        logic [`LSU_XLEN-1:0] wdata;
    } mem_req_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        // one bit per byte lane
        logic [`LSU_XLEN/8-1:0] sel;
        logic [`LSU_XLEN-1:0]   adr;
        logic [`LSU_XLEN-1:0]   dat;
    } wb_m2s_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic                 ack;
        logic [`LSU_XLEN-1:0] dat;
    } wb_s2m_t;

endpackage

// File: hdl/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// integer register and address width
`define LSU_XLEN 64

// data ram depth in 64-bit words
`define LSU_RAM_WORDS 256

// major opcode field, instr[6:2]
// LOAD is the I-type memory read group
`define LSU_OPC_LOAD 5'b00000

// STORE is the S-type memory write group
`define LSU_OPC_STORE 5'b01000

`endif

// File: hdl/wb_master.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module wb_master (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   start_i,
    input  lsu_pkg::mem_req_t      req_i,
    input  logic                   misalign_i,
    input  logic [`LSU_XLEN/8-1:0] sel_i,
    input  logic [`LSU_XLEN-1:0]   wdata_i,
    input  lsu_pkg::wb_s2m_t       bus_i,
    output lsu_pkg::wb_m2s_t       bus_o,
    output logic                   ready_o,
    output logic                   fin_o,
    output logic                   fin_load_o,
    output lsu_pkg::acc_size_e     fin_size_o,
    output logic                   fin_unsigned_o,
    output logic [2:0]             fin_off_o,
    output logic                   fin_misalign_o,
    output logic [`LSU_XLEN-1:0]   rdata_o
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_FIN
    } state_e;

    state_e                 state_q;
    logic                   accept;
    logic                   go_bus;
    logic                   ld_q;
    logic                   st_q;
    logic                   uns_q;
    logic                   mis_q;
    acc_size_e              size_q;
    logic [`LSU_XLEN-1:0]   addr_q;
    logic [`LSU_XLEN/8-1:0] sel_q;
    logic [`LSU_XLEN-1:0]   wdata_q;
    logic [`LSU_XLEN-1:0]   rdata_q;

    // handshake with the caller
    assign accept = start_i && (state_q == ST_IDLE);
    // only aligned loads and stores touch the bus
    assign go_bus = (req_i.is_load || req_i.is_store) && !misalign_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= go_bus ? ST_BUS : ST_FIN;
                    end
                end
                ST_BUS: begin
                    // hold the cycle until the slave acks
                    if (bus_i.ack) begin
                        state_q <= ST_FIN;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // request fields held for the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            ld_q    <= req_i.is_load;
            st_q    <= req_i.is_store;
            uns_q   <= req_i.unsigned_ld;
            size_q  <= req_i.size;
            addr_q  <= req_i.addr;
            mis_q   <= misalign_i;
            sel_q   <= sel_i;
            wdata_q <= wdata_i;
        end
        // read word sampled on the ack edge
        if ((state_q == ST_BUS) && bus_i.ack) begin
            rdata_q <= bus_i.dat;
        end
    end

    // cyc and stb drop on the edge that sees ack
    assign bus_o.cyc = (state_q == ST_BUS);
    assign bus_o.stb = (state_q == ST_BUS);
    assign bus_o.we  = st_q;
    assign bus_o.sel = sel_q;
    // word address, lanes picked by sel
    assign bus_o.adr = {addr_q[`LSU_XLEN-1:3], 3'b000};
    assign bus_o.dat = wdata_q;

    assign ready_o        = (state_q == ST_IDLE);
    // one cycle pulse, fields valid alongside
    assign fin_o          = (state_q == ST_FIN);
    assign fin_load_o     = ld_q;
    assign fin_size_o     = size_q;
    assign fin_unsigned_o = uns_q;
    assign fin_off_o      = addr_q[2:0];
    assign fin_misalign_o = mis_q;
    assign rdata_o        = rdata_q;

endmodule

// File: src.f
+incdir+hdl
+incdir+test
hdl/lsu_pkg.sv
hdl/ls_decode.sv
hdl/lane_align.sv
hdl/wb_master.sv
hdl/load_extend.sv
hdl/data_ram.sv
hdl/ls_stage.sv
test/tb_ls_stage.sv

// File: test/tb_vectors.svh
// one row per request, expected values filled in by the byte model
// columns: instr, instr_last, addr, rs2, wb_data, exp_result, exp_misalign, exp_latency

localparam int NUM_VECTORS = 50;

// addi x0, x0, 0
localparam logic [31:0] NOP_INSTR  = 32'h0000_0013;
// addi x3, x0, 5
localparam logic [31:0] ADDI_INSTR = 32'h0050_0193;

// funct3 width and sign codes
localparam logic [2:0] F3_B  = 3'b000;
localparam logic [2:0] F3_H  = 3'b001;
localparam logic [2:0] F3_W  = 3'b010;
localparam logic [2:0] F3_D  = 3'b011;
localparam logic [2:0] F3_BU = 3'b100;
localparam logic [2:0] F3_HU = 3'b101;
localparam logic [2:0] F3_WU = 3'b110;

typedef struct packed {
    logic [31:0] instr;
    logic [31:0] instr_last;
    logic [63:0] addr;
    logic [63:0] rs2;
    logic [63:0] wb_data;
    logic [63:0] exp_result;
    logic        exp_misalign;
    int          exp_latency;
} vec_t;

vec_t vectors [NUM_VECTORS];

task automatic build_vectors();
    // doubleword round trip
    put_store(F3_D, 5'd5, 64'h100, 64'h0123_4567_89ab_cdef, NOP_INSTR, 64'h0);
    put_load(F3_D, 5'd6, 64'h100);
    // byte lanes over a random background, word read after each store
    put_store(F3_D, 5'd5, 64'h200, rand64(), NOP_INSTR, 64'h0);
    for (int i = 0; i < 8; i++) begin
        put_store(F3_B, 5'd5, 64'h200 + 64'(i), rand64(), NOP_INSTR, 64'h0);
        put_load(F3_D, 5'd6, 64'h200);
    end
    // half lanes
    put_store(F3_D, 5'd5, 64'h210, rand64(), NOP_INSTR, 64'h0);
    for (int i = 0; i < 4; i++) begin
        put_store(F3_H, 5'd5, 64'h210 + 64'(2 * i), rand64(), NOP_INSTR, 64'h0);
        put_load(F3_D, 5'd6, 64'h210);
    end
    // word lanes
    put_store(F3_D, 5'd5, 64'h220, rand64(), NOP_INSTR, 64'h0);
    for (int i = 0; i < 2; i++) begin
        put_store(F3_W, 5'd5, 64'h220 + 64'(4 * i), rand64(), NOP_INSTR, 64'h0);
        put_load(F3_D, 5'd6, 64'h220);
    end
    // every byte has bit 7 set, so sign and zero fill differ
    put_store(F3_D, 5'd5, 64'h300, 64'hf0e1_d2c3_b4a5_9687, NOP_INSTR, 64'h0);
    put_load(F3_B, 5'd6, 64'h303);
    put_load(F3_BU, 5'd6, 64'h303);
    put_load(F3_H, 5'd6, 64'h306);
    put_load(F3_HU, 5'd6, 64'h306);
    put_load(F3_W, 5'd6, 64'h304);
    put_load(F3_WU, 5'd6, 64'h304);
    // previous load writes x7, store reads x7
    put_store(F3_D, 5'd7, 64'h400, 64'hdead_beef_dead_beef,
              enc_load(F3_D, 5'd7), 64'h1122_3344_5566_7788);
    put_load(F3_D, 5'd6, 64'h400);
    // previous load writes x8, no forwarding
    put_store(F3_D, 5'd7, 64'h408, 64'h0bad_f00d_0bad_f00d,
              enc_load(F3_D, 5'd8), 64'hffff_0000_ffff_0000);
    put_load(F3_D, 5'd6, 64'h408);
    // misaligned accesses, word at 0x100 must survive
    put_store(F3_H, 5'd5, 64'h101, rand64(), NOP_INSTR, 64'h0);
    put_store(F3_W, 5'd5, 64'h102, rand64(), NOP_INSTR, 64'h0);
    put_store(F3_D, 5'd5, 64'h104, rand64(), NOP_INSTR, 64'h0);
    put_load(F3_H, 5'd6, 64'h301);
    put_load(F3_D, 5'd6, 64'h100);
    // not a memory op
    put_other(ADDI_INSTR);
endtask

// File: test/tb_ls_stage.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module tb_ls_stage;

    logic        clk;
    logic        rst_n_i;
    logic        valid_i;
    logic [31:0] instr_i;
    logic [31:0] instr_last_i;
    logic [63:0] addr_i;
    logic [63:0] rs2_i;
    logic [63:0] wb_data_i;
    logic        ready_o;
    logic        done_o;
    logic        misalign_o;
    logic [63:0] result_o;

    localparam int MODEL_BYTES = `LSU_RAM_WORDS * 8;

    // byte image of the data ram, updated as the table is built
    logic [7:0] model_mem [MODEL_BYTES];
    int         n_built;
    int         n_checks;
    int         n_mismatch;
    int         n_other;
    int         cycle_cnt;

    `include "tb_vectors.svh"

    // at most four cycles per vector, with slack
    localparam int TIMEOUT_CYCLES = 8 * NUM_VECTORS + 50;

    ls_stage uut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .addr_i       (addr_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .ready_o      (ready_o),
        .done_o       (done_o),
        .misalign_o   (misalign_o),
        .result_o     (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_cnt);
        $display("TB FAILED");
        $finish;
    end

    // load with rs1 = x1 and zero offset, address comes in on addr_i
    function automatic logic [31:0] enc_load(input logic [2:0] f3, input logic [4:0] rd);
        return {12'h000, 5'd1, f3, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_store(input logic [2:0] f3, input logic [4:0] rs2);
        return {7'h00, rs2, 5'd1, f3, 5'h00, 7'b0100011};
    endfunction

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // natural alignment, address a multiple of the access width
    function automatic logic is_aligned(input logic [63:0] addr, input logic [1:0] size);
        return (addr & ((64'd1 << size) - 64'd1)) == 64'd0;
    endfunction

    function automatic void model_store(input logic [63:0] addr, input logic [1:0] size,
                                        input logic [63:0] data);
        int base;
        base = int'(addr % 64'(MODEL_BYTES));
        for (int i = 0; i < (1 << size); i++) begin
            model_mem[base + i] = data[8*i +: 8];
        end
    endfunction

    function automatic logic [63:0] model_load(input logic [63:0] addr, input logic [1:0] size,
                                               input logic zero_ext);
        logic [63:0] val;
        int          base;
        int          nb;
        base = int'(addr % 64'(MODEL_BYTES));
        nb   = 1 << size;
        val  = 64'h0;
        for (int i = 0; i < nb; i++) begin
            val[8*i +: 8] = model_mem[base + i];
        end
        // signed loads copy the field's top bit upward
        if (!zero_ext && val[8*nb-1]) begin
            for (int i = nb; i < 8; i++) begin
                val[8*i +: 8] = 8'hff;
            end
        end
        return val;
    endfunction

    function automatic void add_entry(input logic [31:0] instr, input logic [31:0] last,
                                      input logic [63:0] addr, input logic [63:0] rs2,
                                      input logic [63:0] wb_data, input logic [63:0] exp_result,
                                      input logic exp_misalign, input int exp_latency);
        if (n_built >= NUM_VECTORS) begin
            $display("vector table full, entry %0d dropped", n_built);
            n_other++;
        end else begin
            vectors[n_built].instr        = instr;
            vectors[n_built].instr_last   = last;
            vectors[n_built].addr         = addr;
            vectors[n_built].rs2          = rs2;
            vectors[n_built].wb_data      = wb_data;
            vectors[n_built].exp_result   = exp_result;
            vectors[n_built].exp_misalign = exp_misalign;
            vectors[n_built].exp_latency  = exp_latency;
        end
        n_built++;
    endfunction

    function automatic void put_load(input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [63:0] addr);
        logic        mis;
        logic [63:0] exp;
        mis = !is_aligned(addr, f3[1:0]);
        exp = mis ? 64'h0 : model_load(addr, f3[1:0], f3[2]);
        add_entry(enc_load(f3, rd), NOP_INSTR, addr, 64'h0, 64'h0, exp, mis, mis ? 1 : 3);
    endfunction

    function automatic void put_store(input logic [2:0] f3, input logic [4:0] rs2_reg,
                                      input logic [63:0] addr, input logic [63:0] rs2_val,
                                      input logic [31:0] last, input logic [63:0] wb_data);
        logic        mis;
        logic [63:0] data;
        mis = !is_aligned(addr, f3[1:0]);
        // load result not yet written back, take it from wb_data
        if (last[6:0] == 7'b0000011 && last[11:7] == rs2_reg && rs2_reg != 5'd0) begin
            data = wb_data;
        end else begin
            data = rs2_val;
        end
        if (!mis) begin
            model_store(addr, f3[1:0], data);
        end
        add_entry(enc_store(f3, rs2_reg), last, addr, rs2_val, wb_data, 64'h0, mis,
                  mis ? 1 : 3);
    endfunction

    function automatic void put_other(input logic [31:0] instr);
        add_entry(instr, NOP_INSTR, 64'h0, 64'h0, 64'h0, 64'h0, 1'b0, 1);
    endfunction

    // drive one row, wait for accept and done, then check
    task automatic run_vector(input int v);
        int lat;
        lat          = 0;
        valid_i      = 1'b1;
        instr_i      = vectors[v].instr;
        instr_last_i = vectors[v].instr_last;
        addr_i       = vectors[v].addr;
        rs2_i        = vectors[v].rs2;
        wb_data_i    = vectors[v].wb_data;
        // inputs held until the stage is ready
        while (ready_o !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        // this edge accepts
        @(posedge clk);
        #1;
        valid_i = 1'b0;
        while (done_o !== 1'b1) begin
            if (ready_o !== 1'b0) begin
                $display("MISMATCH at %0t: vector %0d ready_o high before done_o", $time, v);
                n_mismatch++;
            end
            @(posedge clk);
            #1;
            lat++;
        end
        n_checks += 3;
        if (result_o !== vectors[v].exp_result) begin
            $display("MISMATCH at %0t: vector %0d result_o %h, expected %h",
                     $time, v, result_o, vectors[v].exp_result);
            n_mismatch++;
        end
        if (misalign_o !== vectors[v].exp_misalign) begin
            $display("MISMATCH at %0t: vector %0d misalign_o %b, expected %b",
                     $time, v, misalign_o, vectors[v].exp_misalign);
            n_mismatch++;
        end
        if (lat != vectors[v].exp_latency) begin
            $display("MISMATCH at %0t: vector %0d latency %0d cycles, expected %0d",
                     $time, v, lat, vectors[v].exp_latency);
            n_mismatch++;
        end
    endtask

    initial begin
        void'($urandom(12));
        rst_n_i      = 1'b0;
        valid_i      = 1'b0;
        instr_i      = NOP_INSTR;
        instr_last_i = NOP_INSTR;
        addr_i       = 64'h0;
        rs2_i        = 64'h0;
        wb_data_i    = 64'h0;
        n_built      = 0;
        n_checks     = 0;
        n_mismatch   = 0;
        n_other      = 0;
        build_vectors();
        if (n_built != NUM_VECTORS) begin
            $display("vector table sized for %0d entries, %0d built", NUM_VECTORS, n_built);
            n_other++;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        // idle outputs and quiet bus after reset
        n_checks++;
        if (ready_o !== 1'b1 || done_o !== 1'b0 || misalign_o !== 1'b0
            || uut.wb_m2s.cyc !== 1'b0 || uut.wb_m2s.stb !== 1'b0) begin
            $display("MISMATCH at %0t: outputs not idle after reset", $time);
            n_mismatch++;
        end
        for (int v = 0; v < NUM_VECTORS; v++) begin
            run_vector(v);
        end
        $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
